/* rtl/fetch_pkg.sv */
package fetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [31:0] reset_pc = 32'h3000_0000;

    // SDRAM sits at A000_0000 to BFFF_FFFF
    localparam logic [3:0] sdram_base_nibble = 4'hA;
    localparam logic [3:0] sdram_end_nibble  = 4'hB;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int line_words  = 4;
    localparam int line_bits   = 128;
    localparam int offset_bits = 4;
    localparam int index_bits  = 4;
    localparam int tag_bits    = 24;

    // AXI read encodings
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr  = 2'b01;

    typedef enum logic [1:0] {
        idle = 2'b00,
        busy = 2'b01,
        read = 2'b10
    } fetch_state_e;

    // A fetch address is read either as a plain word or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_bits-1:0]    tag;
            logic [index_bits-1:0]  index;
            logic [offset_bits-1:0] offset;
        } fields;
    } fetch_addr_u;

endpackage

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            idu_ready,
    input  logic                            exu_dnpc_valid,
    input  logic [31:0]                     exu_dnpc,
    output logic                            ifu_valid,
    output logic [31:0]                     inst,
    output logic [31:0]                     fetch_pc,
    output logic                            pc_update,
    output logic                            access_fault,

    output logic [31:0]                     icache_addr,
    input  logic                            icache_hit,
    input  logic [31:0]                     icache_data,
    input  logic                            mem_req,
    input  logic [31:0]                     mem_addr,
    output logic [fetch_pkg::line_bits-1:0] mem_data,
    output logic                            mem_ready,

    output logic                            arvalid,
    input  logic                            arready,
    output logic [31:0]                     araddr,
    output logic [7:0]                      arlen,
    output logic [1:0]                      arburst,
    output logic                            rready,
    input  logic                            rvalid,
    input  logic [1:0]                      rresp,
    input  logic [31:0]                     rdata,
    input  logic                            rlast
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::fetch_state_e next_state;
    fetch_pkg::fetch_addr_u  pc;
    fetch_pkg::fetch_addr_u  refill_base;
    fetch_pkg::fetch_addr_u  next_beat_addr;

    logic        redirect;
    logic [31:0] redirect_pc;
    logic        redirect_pending;
    logic [31:0] redirect_target;
    logic [31:0] dnpc;
    logic        launch;
    logic        miss_is_sdram;
    logic        refill_burst;
    logic [1:0]  beat_cnt;
    logic        beat_fire;
    logic        last_beat;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program counter and redirect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A redirect seen while the PC cannot move is kept until the next update
    assign redirect    = exu_dnpc_valid | redirect_pending;
    assign redirect_pc = exu_dnpc_valid ? exu_dnpc : redirect_target;
    assign dnpc        = redirect ? redirect_pc : pc.raw + 32'd4;

    assign pc_update   = (next_state == fetch_pkg::idle) && idu_ready;
    assign icache_addr = pc.raw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc.raw <= fetch_pkg::reset_pc;
        end else if (pc_update) begin
            pc.raw <= dnpc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_pending <= 1'b0;
        end else if (pc_update) begin
            redirect_pending <= 1'b0;
        end else if (exu_dnpc_valid) begin
            redirect_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (exu_dnpc_valid) begin
            redirect_target <= exu_dnpc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state = state;
        case (state)
            fetch_pkg::idle: begin
                // A pending redirect skips the refill of a line nobody wants
                if (idu_ready && !redirect && !icache_hit && mem_req) begin
                    next_state = fetch_pkg::busy;
                end
            end
            fetch_pkg::busy: begin
                if (mem_ready) begin
                    next_state = fetch_pkg::read;
                end
            end
            fetch_pkg::read: begin
                if (idu_ready) begin
                    next_state = fetch_pkg::idle;
                end
            end
            default: begin
                next_state = fetch_pkg::idle;
            end
        endcase
    end

    assign launch        = (state == fetch_pkg::idle) && (next_state == fetch_pkg::busy);
    assign miss_is_sdram = (mem_addr[31:28] == fetch_pkg::sdram_base_nibble) ||
                           (mem_addr[31:28] == fetch_pkg::sdram_end_nibble);

    assign beat_fire = rvalid && rready;
    assign last_beat = refill_burst ? rlast
                                    : (beat_cnt == 2'(fetch_pkg::line_words - 1));

    // Single reads step through the line one word at a time
    always_comb begin
        next_beat_addr = refill_base;
        next_beat_addr.fields.offset = {beat_cnt + 2'd1, 2'b00};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= fetch_pkg::idle;
            ifu_valid    <= 1'b0;
            arvalid      <= 1'b0;
            rready       <= 1'b0;
            mem_ready    <= 1'b0;
            access_fault <= 1'b0;
            refill_burst <= 1'b0;
            beat_cnt     <= 2'd0;
        end else begin
            state     <= next_state;
            mem_ready <= 1'b0;
            case (state)
                fetch_pkg::idle: begin
                    if (idu_ready) begin
                        ifu_valid <= icache_hit && !redirect;
                    end
                    if (launch) begin
                        arvalid      <= 1'b1;
                        refill_burst <= miss_is_sdram;
                        beat_cnt     <= 2'd0;
                    end
                end
                fetch_pkg::busy: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (beat_fire) begin
                        beat_cnt <= beat_cnt + 2'd1;
                        if (last_beat) begin
                            rready       <= 1'b0;
                            mem_ready    <= 1'b1;
                            access_fault <= (rresp != fetch_pkg::resp_okay);
                        end else if (!refill_burst) begin
                            arvalid <= 1'b1;
                        end
                    end
                end
                fetch_pkg::read: begin
                    // The line is in the cache now, so the word comes from there
                    if (idu_ready) begin
                        ifu_valid <= !redirect;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch_pkg::idle && idu_ready && icache_hit) begin
            inst     <= icache_data;
            fetch_pc <= pc.raw;
        end
        if (state == fetch_pkg::read && idu_ready) begin
            inst     <= icache_data;
            fetch_pc <= pc.raw;
        end
        if (launch) begin
            refill_base.raw <= mem_addr;
            araddr          <= mem_addr;
            arlen           <= miss_is_sdram ? 8'(fetch_pkg::line_words - 1) : 8'd0;
            arburst         <= miss_is_sdram ? fetch_pkg::burst_incr : fetch_pkg::burst_fixed;
        end
        if (state == fetch_pkg::busy && beat_fire) begin
            mem_data[beat_cnt*32 +: 32] <= rdata;
            if (!last_beat && !refill_burst) begin
                araddr <= next_beat_addr.raw;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ar_held_until_ready: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen) &&
                                $stable(arburst));

    mem_ready_one_cycle: assert property (@(posedge clk) disable iff (rst)
        mem_ready |=> !mem_ready);

    no_rready_in_idle: assert property (@(posedge clk) disable iff (rst)
        state == fetch_pkg::idle |-> !rready);

endmodule

/* rtl/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic                            clk,
    input  logic                            rst,

    input  logic [31:0]                     icache_addr,
    output logic                            icache_hit,
    output logic [31:0]                     icache_data,

    output logic                            mem_req,
    output logic [31:0]                     mem_addr,
    input  logic [fetch_pkg::line_bits-1:0] mem_data,
    input  logic                            mem_ready
);

    fetch_pkg::fetch_addr_u lookup;

    logic [2**fetch_pkg::index_bits-1:0] valid;
    logic [fetch_pkg::tag_bits-1:0]      tag_mem  [2**fetch_pkg::index_bits];
    logic [fetch_pkg::line_bits-1:0]     data_mem [2**fetch_pkg::index_bits];

    logic [fetch_pkg::line_bits-1:0]     line;
    logic [31:0]                         line_word [fetch_pkg::line_words];
    logic [fetch_pkg::offset_bits-3:0]   word_sel;
    logic                                tag_match;

    assign lookup.raw = icache_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign line      = data_mem[lookup.fields.index];
    assign tag_match = (tag_mem[lookup.fields.index] == lookup.fields.tag);
    assign word_sel  = lookup.fields.offset[fetch_pkg::offset_bits-1:2];

    // Word 0 of a line sits in the low bits, matching the beat order of a refill
    always_comb begin
        for (int w = 0; w < fetch_pkg::line_words; w++) begin
            line_word[w] = line[w*32 +: 32];
        end
    end

    assign icache_hit  = valid[lookup.fields.index] && tag_match;
    assign icache_data = line_word[word_sel];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Refill
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The request stays up until the line is written and the lookup hits
    assign mem_req  = !icache_hit;
    assign mem_addr = {lookup.raw[31:fetch_pkg::offset_bits], {fetch_pkg::offset_bits{1'b0}}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (mem_ready) begin
            valid[lookup.fields.index] <= 1'b1;
        end
    end

    // The fetch address does not move during a refill, so the lookup index is the fill index
    always_ff @(posedge clk) begin
        if (mem_ready) begin
            tag_mem[lookup.fields.index]  <= lookup.fields.tag;
            data_mem[lookup.fields.index] <= mem_data;
        end
    end

    fill_only_on_request: assert property (@(posedge clk) disable iff (rst)
        mem_ready |-> mem_req);

endmodule

/* rtl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic        clk,
    input  logic        rst,

    input  logic        idu_ready,
    input  logic        exu_dnpc_valid,
    input  logic [31:0] exu_dnpc,
    output logic        ifu_valid,
    output logic [31:0] inst,
    output logic [31:0] fetch_pc,
    output logic        pc_update,
    output logic        access_fault,

    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic [1:0]  arburst,
    output logic        rready,
    input  logic        rvalid,
    input  logic [1:0]  rresp,
    input  logic [31:0] rdata,
    input  logic        rlast
);

    logic [31:0]                     icache_addr;
    logic                            icache_hit;
    logic [31:0]                     icache_data;
    logic                            mem_req;
    logic [31:0]                     mem_addr;
    logic [fetch_pkg::line_bits-1:0] mem_data;
    logic                            mem_ready;

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .idu_ready      (idu_ready),
        .exu_dnpc_valid (exu_dnpc_valid),
        .exu_dnpc       (exu_dnpc),
        .ifu_valid      (ifu_valid),
        .inst           (inst),
        .fetch_pc       (fetch_pc),
        .pc_update      (pc_update),
        .access_fault   (access_fault),
        .icache_addr    (icache_addr),
        .icache_hit     (icache_hit),
        .icache_data    (icache_data),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .mem_ready      (mem_ready),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .arlen          (arlen),
        .arburst        (arburst),
        .rready         (rready),
        .rvalid         (rvalid),
        .rresp          (rresp),
        .rdata          (rdata),
        .rlast          (rlast)
    );

    icache u_icache (
        .clk         (clk),
        .rst         (rst),
        .icache_addr (icache_addr),
        .icache_hit  (icache_hit),
        .icache_data (icache_data),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .mem_ready   (mem_ready)
    );

endmodule

/* verif/axi_read_mem.sv */
`timescale 1ns/1ps

module axi_read_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic [1:0]  arburst,
    input  logic        rready,
    output logic        rvalid,
    output logic [1:0]  rresp,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        protocol_error
);

    localparam logic [31:0] data_key    = 32'h5A5A_0000;
    localparam logic [1:0]  resp_slverr = 2'b10;
    localparam int          beat_limit  = 100;

    logic [31:0] addr;
    logic [7:0]  len;
    logic [1:0]  burst;
    logic        sdram;

    // Serves one read at a time with its address phase first and then every beat
    task automatic serve_read();
        int beat;
        int wait_cycles;
        repeat ($urandom_range(3, 0)) @(posedge clk);
        #1 arready = 1'b1;
        @(posedge clk);
        addr  = araddr;
        len   = arlen;
        burst = arburst;
        sdram = (addr[31:28] == fetch_pkg::sdram_base_nibble) ||
                (addr[31:28] == fetch_pkg::sdram_end_nibble);
        #1 arready = 1'b0;
        // Only the SDRAM controller takes bursts
        if (!sdram && len != 8'd0) begin
            protocol_error = 1'b1;
        end
        for (beat = 0; beat <= len; beat++) begin
            repeat ($urandom_range(3, 0)) @(posedge clk);
            #1;
            rvalid = 1'b1;
            rdata  = addr ^ data_key;
            rresp  = (addr[31:28] == 4'hF) ? resp_slverr : fetch_pkg::resp_okay;
            rlast  = (beat == len);
            wait_cycles = 0;
            do begin
                @(posedge clk);
                wait_cycles++;
            end while (!rready && wait_cycles < beat_limit);
            if (!rready) begin
                protocol_error = 1'b1;
            end
            #1;
            rvalid = 1'b0;
            rlast  = 1'b0;
            if (burst == 2'b01) begin
                addr = addr + 32'd4;
            end
        end
    endtask

    initial begin
        arready        = 1'b0;
        rvalid         = 1'b0;
        rresp          = fetch_pkg::resp_okay;
        rdata          = '0;
        rlast          = 1'b0;
        protocol_error = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && arvalid) begin
                serve_read();
            end
        end
    end

endmodule

/* verif/tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch;

    localparam logic [31:0] data_key   = 32'h5A5A_0000;
    localparam int          wait_limit = 200;

    logic        clk;
    logic        rst;
    logic        idu_ready;
    logic        exu_dnpc_valid;
    logic [31:0] exu_dnpc;
    logic        ifu_valid, pc_update, access_fault;
    logic [31:0] inst, fetch_pc;
    logic        arvalid, arready, rready, rvalid, rlast, protocol_error;
    logic [31:0] araddr, rdata;
    logic [7:0]  arlen;
    logic [1:0]  arburst, rresp;

    int          error_count    = 0;
    int          test_errors    = 0;
    int          test_num       = 0;
    int          failed_tests   = 0;
    int          words_seen     = 0;
    int          ar_count       = 0;
    int          burst_refills  = 0;
    int          single_refills = 0;
    logic [31:0] expected_pc    = fetch_pkg::reset_pc;
    logic [31:0] last_ar_addr;
    logic        refill_sdram;

    fetch_top UUT (.*);

    axi_read_mem u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic in_sdram(input logic [31:0] addr);
        return (addr[31:28] == fetch_pkg::sdram_base_nibble) ||
               (addr[31:28] == fetch_pkg::sdram_end_nibble);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        error_count++;
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_words(input int count);
        int target;
        int cycles;
        target = words_seen + count;
        cycles = 0;
        while (words_seen < target && cycles < wait_limit * count) begin
            next_cycle();
            cycles++;
        end
        if (words_seen < target) abort_on_timeout("fetched words");
    endtask

    // Stops while the second word of a line is shown, so the next fetch is a hit
    task automatic wait_second_word();
        int cycles;
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
        end while (!(ifu_valid && fetch_pc[3:0] == 4'h4) && cycles < wait_limit);
        if (!(ifu_valid && fetch_pc[3:0] == 4'h4)) abort_on_timeout("the second word of a line");
    endtask

    task automatic pulse_redirect(input logic [31:0] target);
        exu_dnpc_valid = 1'b1;
        exu_dnpc       = target;
        next_cycle();
        exu_dnpc_valid = 1'b0;
    endtask

    task automatic wait_delivery(input logic forbid_ar);
        int cycles;
        cycles = 0;
        while (!ifu_valid && cycles < wait_limit) begin
            assert (!(forbid_ar && arvalid))
                else report_problem("arvalid raised although the line was cached");
            next_cycle();
            cycles++;
        end
        if (!ifu_valid) abort_on_timeout("a valid word");
    endtask

    task automatic close_test(input string name);
        test_num++;
        if (error_count == test_errors) begin
            $display("Test %0d %s: passed", test_num, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", test_num, name,
                     error_count - test_errors);
            failed_tests++;
        end
        test_errors = error_count;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode stand-in and bus checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A redirect in the same cycle wins over the sequential step
    always @(posedge clk) begin
        if (!rst && ifu_valid && idu_ready) begin
            assert (fetch_pc == expected_pc)
                else report_mismatch("fetch_pc", fetch_pc, expected_pc);
            assert (inst == (expected_pc ^ data_key))
                else report_mismatch("inst", inst, expected_pc ^ data_key);
            words_seen  <= words_seen + 1;
            expected_pc <= expected_pc + 32'd4;
        end
        if (!rst && exu_dnpc_valid) expected_pc <= exu_dnpc;
    end

    always @(posedge clk) begin
        if (!rst && arvalid && arready) begin
            if (in_sdram(araddr)) begin
                assert (arlen == 8'd3) else report_mismatch("arlen", arlen, 32'd3);
                assert (arburst == 2'b01) else report_mismatch("arburst", arburst, 32'd1);
            end else begin
                assert (arlen == 8'd0) else report_mismatch("arlen", arlen, 32'd0);
                assert (arburst == 2'b00) else report_mismatch("arburst", arburst, 32'd0);
            end
            if (ar_count == 0) begin
                assert (araddr[3:0] == 4'h0)
                    else report_mismatch("araddr", araddr, {araddr[31:4], 4'h0});
                refill_sdram <= in_sdram(araddr);
            end else begin
                assert (araddr == last_ar_addr + 32'd4)
                    else report_mismatch("araddr", araddr, last_ar_addr + 32'd4);
            end
            last_ar_addr <= araddr;
            ar_count     <= ar_count + 1;
        end
        if (!rst && UUT.u_fetch_unit.mem_ready) begin
            assert (ar_count == (refill_sdram ? 1 : 4))
                else report_problem($sformatf("refill used %0d address handshakes", ar_count));
            if (refill_sdram) burst_refills <= burst_refills + 1;
            else single_refills <= single_refills + 1;
            ar_count <= 0;
        end
    end

    stall_holds_word: assert property (@(posedge clk) disable iff (rst)
        ifu_valid && !idu_ready |=> ifu_valid && $stable(inst) && $stable(fetch_pc))
        else report_problem("shown word changed while decode was stalled");

    stall_holds_pc: assert property (@(posedge clk) disable iff (rst)
        !idu_ready |=> $stable(UUT.u_fetch_unit.icache_addr))
        else report_problem("PC moved while decode was stalled");

    update_needs_ready: assert property (@(posedge clk) disable iff (rst)
        pc_update |-> idu_ready)
        else report_problem("pc_update raised while decode was stalled");

    pc_moves_on_update: assert property (@(posedge clk) disable iff (rst)
        !pc_update |=> $stable(UUT.u_fetch_unit.icache_addr))
        else report_problem("PC moved without pc_update");

    hit_next_cycle: assert property (@(posedge clk) disable iff (rst)
        UUT.u_fetch_unit.state == fetch_pkg::idle && idu_ready &&
        UUT.u_icache.icache_hit && !exu_dnpc_valid |=> ifu_valid)
        else report_problem("cache hit gave no word on the next cycle");

    bus_model_happy: assert property (@(posedge clk) disable iff (rst) !protocol_error)
        else report_problem("memory model saw an illegal or stalled read");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int stall_target;
        int spans;
        void'($urandom(32'hd8523366));
        rst            = 1'b1;
        idu_ready      = 1'b0;
        exu_dnpc_valid = 1'b0;
        exu_dnpc       = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!ifu_valid && !arvalid && !rready && !access_fault &&
                !UUT.u_fetch_unit.mem_ready)
            else report_problem("fetch outputs not quiet after reset");
        assert (UUT.u_fetch_unit.icache_addr == fetch_pkg::reset_pc)
            else report_mismatch("pc", UUT.u_fetch_unit.icache_addr, fetch_pkg::reset_pc);
        idu_ready = 1'b1;
        wait_words(12);
        // Twelve words from an aligned start fill three lines, each refilled once
        assert (single_refills == 3)
            else report_problem($sformatf("%0d single-read refills for three lines",
                                          single_refills));
        close_test("sequential fetch from reset");

        wait_second_word();
        pulse_redirect(fetch_pkg::reset_pc);
        wait_delivery(1'b1);
        wait_words(4);
        close_test("cache reuse");

        wait_second_word();
        pulse_redirect(32'hA000_0100);
        wait_words(8);
        assert (burst_refills == 2)
            else report_problem($sformatf("%0d burst refills for two SDRAM lines",
                                          burst_refills));
        close_test("refill shape");

        stall_target = words_seen + 16;
        spans = 0;
        while (words_seen < stall_target && spans < wait_limit) begin
            idu_ready = ($urandom_range(2, 0) != 0);
            repeat ($urandom_range(4, 1)) next_cycle();
            spans++;
        end
        idu_ready = 1'b1;
        if (words_seen < stall_target) abort_on_timeout("words under back-pressure");
        close_test("back-pressure");

        // The second redirect lands while the first target is still refilling
        wait_second_word();
        pulse_redirect(32'h8000_0200);
        next_cycle();
        pulse_redirect(32'h8000_0340);
        wait_delivery(1'b0);
        assert (fetch_pc == 32'h8000_0340)
            else report_mismatch("fetch_pc", fetch_pc, 32'h8000_0340);
        wait_words(4);
        close_test("redirect");

        wait_second_word();
        pulse_redirect(32'hF000_0040);
        wait_delivery(1'b0);
        assert (access_fault) else report_mismatch("access_fault", access_fault, 32'd1);
        wait_second_word();
        pulse_redirect(32'h2000_0080);
        wait_delivery(1'b0);
        assert (!access_fault) else report_mismatch("access_fault", access_fault, 32'd0);
        close_test("access fault");

        $display("Tests run: %0d, failed: %0d, errors: %0d", test_num, failed_tests, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* compile.f */
rtl/fetch_pkg.sv
rtl/fetch_unit.sv
rtl/icache.sv
rtl/fetch_top.sv
verif/axi_read_mem.sv
verif/tb_fetch.sv

/* Bender.yml */
package:
  name: fetch_subsystem

sources:
  - files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/icache.sv
      - rtl/fetch_top.sv
  - target: test
    files:
      - verif/axi_read_mem.sv
      - verif/tb_fetch.sv
